// ==== hw/pkt_test_pkg.sv ====
// shared types, address table and register map; LANES is a module parameter, 1 to 8 lanes
package pkt_test_pkg;

	//////////////////////////////////////////////////////////////////////
	// stream and control types

	// one lane of one cycle, sop and one-hot eop never share a beat
	typedef struct packed {
		logic sop;
		logic [7:0] eop;
		logic [63:0] data;
	} lane_beat_t;

	// generator controls, written through REG_CTRL and REG_SEED
	typedef struct packed {
		logic run;
		logic gap_en;
		logic cntr_payload;
		logic [31:0] seed;
	} gen_cfg_t;

	// counters read back by software
	typedef struct packed {
		logic [31:0] pkt_sent;
		logic [31:0] pkt_rcvd;
		logic [15:0] err_count;
	} stat_t;

	//////////////////////////////////////////////////////////////////////
	// packet contents

	// lane i uses entry i mod 5, highest index listed first
	localparam logic [4:0][47:0] DEST_ADDR = {
		48'h0200_5e10_00ff,
		48'h0a1b_2c3d_4e5f,
		48'hffff_ffff_ffff,
		48'h0200_5e10_0002,
		48'h0200_5e10_0001
	};

	// fixed last beat
	localparam logic [63:0] CABOOSE = "caboose.";

	// register map
	localparam logic [3:0] REG_CTRL = 4'd0;
	localparam logic [3:0] REG_SEED = 4'd1;
	localparam logic [3:0] REG_SENT = 4'd2;
	localparam logic [3:0] REG_RCVD = 4'd3;
	localparam logic [3:0] REG_ERR  = 4'd4;

	// number of set bits in up to 8 lane flags
	function automatic logic [3:0] count_ones(input logic [7:0] v);
		logic [3:0] n;
		n = '0;
		for (int i = 0; i < 8; i++)
			n += 4'(v[i]);
		return n;
	endfunction

endpackage

// ==== hw/prbs_source.sv ====
// free-running random bits, never stalled; a seed change reloads both LFSRs on the next edge
module prbs_source (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] seed,
	output logic [31:0] rnd
);
	// two galois polynomials, second register seeded with a fixed xor
	localparam logic [31:0] POLY_A = 32'h04c1_1db7;
	localparam logic [31:0] POLY_B = 32'h8020_0003;
	localparam logic [31:0] B_MIX  = 32'h5a5a_5a5a;

	logic [31:0] lfsr_a;
	logic [31:0] lfsr_b;
	logic [31:0] cntr;
	logic [31:0] seed_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr_a <= '1;
			lfsr_b <= '1 ^ B_MIX;
			cntr   <= '0;
			seed_q <= '1;
			rnd    <= '0;
		end else begin
			cntr   <= cntr + 32'd1;
			seed_q <= seed;
			if (seed != seed_q) begin
				lfsr_a <= seed;
				lfsr_b <= seed ^ B_MIX;
			end else begin
				// counter bits disturb the feedback so an all zero state escapes
				lfsr_a <= {lfsr_a[30:0], 1'b0} ^ ((lfsr_a[31] ^ cntr[29]) ? POLY_A : '0);
				lfsr_b <= {lfsr_b[30:0], 1'b0} ^ ((lfsr_b[31] ^ cntr[27]) ? POLY_B : '0);
			end
			// mix rotated copies so neighbouring bits are less correlated
			rnd <= lfsr_a ^ {lfsr_b[15:0], lfsr_b[31:16]} ^ {cntr[7:0], cntr[31:8]};
		end
	end

endmodule

// ==== hw/payload_filler.sv ====
// last generator stage; expects framing already cleaned up, sop never inside an open packet
module payload_filler #(
	parameter int LANES = 2
) (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  ena,
	input  logic [LANES-1:0]                      sop,
	input  logic [LANES-1:0][7:0]                 eop,
	input  logic                                  cntr_payload,
	input  logic [63:0]                           junk,
	input  logic                                  clear,
	output pkt_test_pkg::lane_beat_t [LANES-1:0]  beat
);
	logic [LANES-1:0]       sop_q;
	logic [LANES-1:0][7:0]  eop_q;
	logic [LANES-1:0][63:0] data_q;
	// open state ahead of each lane, top entry carried from last cycle
	logic [LANES:0]         open_c;
	logic                   open_q;

	always_comb begin
		open_c[LANES] = open_q;
		for (int i = LANES - 1; i >= 0; i--)
			open_c[i] = (|eop[i]) ? 1'b0 : (sop[i] | open_c[i+1]);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sop_q  <= '0;
			eop_q  <= '0;
			open_q <= 1'b0;
		end else if (ena) begin
			sop_q  <= sop;
			eop_q  <= eop;
			open_q <= open_c[0];
		end
	end

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		// each lane sees the junk word rotated by its own byte offset
		localparam int ROT = (i * 8) % 64;
		logic [15:0] sernum;
		logic [15:0] ser_now;
		logic [63:0] pcntr;
		logic [63:0] cnt_now;
		logic        middle;

		// a clear restarts numbering with the beat loaded on that same edge
		assign ser_now = clear ? '0 : sernum;
		assign cnt_now = clear ? '0 : pcntr;
		assign middle  = open_c[i+1] & ~(|eop[i]);

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				sernum <= '0;
				pcntr  <= '0;
			end else begin
				sernum <= (ena && sop[i]) ? ser_now + 16'd1 : ser_now;
				pcntr  <= (ena && middle && cntr_payload) ? cnt_now + 64'd1 : cnt_now;
			end
		end

		always_ff @(posedge clk) begin
			if (ena) begin
				if (sop[i])
					data_q[i] <= {pkt_test_pkg::DEST_ADDR[i % 5], ser_now};
				else if (|eop[i])
					data_q[i] <= pkt_test_pkg::CABOOSE;
				else if (middle && cntr_payload)
					data_q[i] <= cnt_now;
				else
					data_q[i] <= 64'({junk, junk} >> ROT);
			end
		end

		assign beat[i].sop  = sop_q[i];
		assign beat[i].eop  = eop_q[i];
		assign beat[i].data = data_q[i];
	end

endmodule

// ==== hw/packet_gen.sv ====
// random framed packets, min two beats; tx_ready low freezes everything but the random source
module packet_gen #(
	parameter int LANES = 2
) (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  pkt_test_pkg::gen_cfg_t                cfg,
	input  logic                                  clear,
	input  logic                                  tx_ready,
	output pkt_test_pkg::lane_beat_t [LANES-1:0]  tx_beat,
	output logic [31:0]                           pkt_sent
);
	logic [31:0] rnd;
	logic [63:0] junk;

	prbs_source prbs_i (
		.clk    (clk),
		.arst_n (arst_n),
		.seed   (cfg.seed),
		.rnd    (rnd)
	);

	assign junk = {rnd, ~{rnd[15:0], rnd[31:16]}};

	//////////////////////////////////////////////////////////////////////
	// per lane suggestions from the random word

	logic [LANES-1:0]      sop_sugg;
	logic [LANES-1:0][7:0] eop_sugg;
	logic [LANES-1:0]      nix_sugg;

	for (genvar i = 0; i < LANES; i++) begin : g_sugg
		localparam int ROT = (i * 9) % 32;
		logic [31:0] r;

		assign r = 32'({rnd, rnd} >> ROT);
		// start about one in eight lane beats
		assign sop_sugg[i] = &r[2:0];
		assign eop_sugg[i] = 8'b1 << r[5:3];
		// three in four end suggestions get blanked, packets grow longer
		assign nix_sugg[i] = |r[7:6];
	end

	//////////////////////////////////////////////////////////////////////
	// stage 0 to 2: capture, thin out, alternation fix-up

	logic [LANES-1:0]      sop0, sop1, sop2;
	logic [LANES-1:0][7:0] eop0, eop1, eop2;
	logic [LANES-1:0]      nix0;
	// open state ahead of each lane, highest lane first in time
	logic [LANES:0]        open_c;
	logic                  open_q;

	always_comb begin
		open_c[LANES] = open_q;
		for (int i = LANES - 1; i >= 0; i--) begin
			if (open_c[i+1])
				open_c[i] = ~(|eop1[i]);
			else
				open_c[i] = sop1[i];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sop0   <= '0;
			eop0   <= '0;
			nix0   <= '0;
			sop1   <= '0;
			eop1   <= '0;
			sop2   <= '0;
			eop2   <= '0;
			open_q <= 1'b0;
		end else if (tx_ready) begin
			// stage 0, run only gates starts so open packets still close
			sop0 <= cfg.run ? sop_sugg : '0;
			eop0 <= eop_sugg;
			nix0 <= nix_sugg;
			// stage 1, gap mode empties the cycle after any start
			sop1 <= (cfg.gap_en && (|sop1)) ? '0 : sop0;
			for (int i = 0; i < LANES; i++)
				eop1[i] <= nix0[i] ? 8'h00 : eop0[i];
			// stage 2, drop starts inside a packet and ends outside one
			for (int i = 0; i < LANES; i++) begin
				sop2[i] <= sop1[i] & ~open_c[i+1];
				eop2[i] <= open_c[i+1] ? eop1[i] : 8'h00;
			end
			open_q <= open_c[0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stage 3: payload, then the sent counter on accepted beats

	payload_filler #(
		.LANES (LANES)
	) filler_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.ena          (tx_ready),
		.sop          (sop2),
		.eop          (eop2),
		.cntr_payload (cfg.cntr_payload),
		.junk         (junk),
		.clear        (clear),
		.beat         (tx_beat)
	);

	logic [LANES-1:0] tx_sop;

	for (genvar i = 0; i < LANES; i++) begin : g_tx_sop
		assign tx_sop[i] = tx_beat[i].sop;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			pkt_sent <= '0;
		else if (clear)
			pkt_sent <= '0;
		else if (tx_ready)
			pkt_sent <= pkt_sent + 32'(pkt_test_pkg::count_ones(8'(tx_sop)));
	end

endmodule

// ==== hw/packet_check.sv ====
// receive checker; counters lag the taken beat by one cycle and wrap without saturation
module packet_check #(
	parameter int LANES = 2
) (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  pkt_test_pkg::lane_beat_t [LANES-1:0]  rx_beat,
	input  logic                                  rx_valid,
	input  logic                                  clear,
	output logic [31:0]                           pkt_rcvd,
	output logic [15:0]                           err_count
);
	logic [LANES-1:0] sop_v;
	logic [LANES-1:0] bad;
	// flags of the beat taken last edge, summed into the counters
	logic [LANES-1:0] sop_q;
	logic [LANES-1:0] err_q;
	logic [LANES:0]   open_c;
	logic             open_q;

	// framing walk, high lane first
	always_comb begin
		open_c[LANES] = open_q;
		for (int i = LANES - 1; i >= 0; i--) begin
			if (|rx_beat[i].eop)
				open_c[i] = 1'b0;
			else if (rx_beat[i].sop)
				open_c[i] = 1'b1;
			else
				open_c[i] = open_c[i+1];
		end
	end

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		logic [7:0]  e;
		logic [63:0] d;
		logic        one_hot;
		logic        hdr_bad;
		logic        tail_bad;
		logic [15:0] exp_ser;

		assign e       = rx_beat[i].eop;
		assign d       = rx_beat[i].data;
		assign sop_v[i] = rx_beat[i].sop;
		assign one_hot = (e != 8'h00) && ((e & (e - 8'd1)) == 8'h00);

		// address and serial number of a first beat
		assign hdr_bad = sop_v[i] &&
			((d[63:16] != pkt_test_pkg::DEST_ADDR[i % 5]) || (d[15:0] != exp_ser));
		// last beat needs an open packet, a clean marker and the trailer
		assign tail_bad = (e != 8'h00) &&
			(!one_hot || !open_c[i+1] || (d != pkt_test_pkg::CABOOSE));
		// several faults in one lane beat still make one error
		assign bad[i] = (sop_v[i] && open_c[i+1]) || hdr_bad || tail_bad;

		// resync on every start, right or wrong
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n)
				exp_ser <= '0;
			else if (clear)
				exp_ser <= '0;
			else if (rx_valid && sop_v[i])
				exp_ser <= d[15:0] + 16'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			open_q    <= 1'b0;
			sop_q     <= '0;
			err_q     <= '0;
			pkt_rcvd  <= '0;
			err_count <= '0;
		end else begin
			if (rx_valid)
				open_q <= open_c[0];
			if (clear) begin
				sop_q     <= '0;
				err_q     <= '0;
				pkt_rcvd  <= '0;
				err_count <= '0;
			end else begin
				sop_q     <= rx_valid ? sop_v : '0;
				err_q     <= rx_valid ? bad : '0;
				pkt_rcvd  <= pkt_rcvd + 32'(pkt_test_pkg::count_ones(8'(sop_q)));
				err_count <= err_count + 16'(pkt_test_pkg::count_ones(8'(err_q)));
			end
		end
	end

endmodule

// ==== hw/pkt_test_csr.sv ====
// register block; clear is a combinational pulse for the cycle of a REG_ERR write
module pkt_test_csr (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   reg_wr,
	input  logic                   reg_rd,
	input  logic [3:0]             reg_addr,
	input  logic [31:0]            reg_wdata,
	output logic [31:0]            reg_rdata,
	input  pkt_test_pkg::stat_t    stat,
	output pkt_test_pkg::gen_cfg_t cfg,
	output logic                   clear
);
	logic [31:0] rd_mux;

	//////////////////////////////////////////////////////////////////////
	// write side

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg.run          <= 1'b0;
			cfg.gap_en       <= 1'b0;
			cfg.cntr_payload <= 1'b0;
			cfg.seed         <= '1;
		end else if (reg_wr) begin
			case (reg_addr)
				// bit 0 run, bit 1 gap, bit 2 counter payload
				pkt_test_pkg::REG_CTRL: begin
					cfg.run          <= reg_wdata[0];
					cfg.gap_en       <= reg_wdata[1];
					cfg.cntr_payload <= reg_wdata[2];
				end
				pkt_test_pkg::REG_SEED: cfg.seed <= reg_wdata;
				default: ;
			endcase
		end
	end

	// counters clear on the same edge that samples the write
	assign clear = reg_wr && (reg_addr == pkt_test_pkg::REG_ERR);

	//////////////////////////////////////////////////////////////////////
	// read side, data held until the next read

	always_comb begin
		case (reg_addr)
			pkt_test_pkg::REG_CTRL: rd_mux = {29'd0, cfg.cntr_payload, cfg.gap_en, cfg.run};
			pkt_test_pkg::REG_SEED: rd_mux = cfg.seed;
			pkt_test_pkg::REG_SENT: rd_mux = stat.pkt_sent;
			pkt_test_pkg::REG_RCVD: rd_mux = stat.pkt_rcvd;
			pkt_test_pkg::REG_ERR:  rd_mux = {16'd0, stat.err_count};
			default:                rd_mux = 32'd0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			reg_rdata <= '0;
		else if (reg_rd)
			reg_rdata <= rd_mux;
	end

endmodule

// ==== hw/pkt_test_top.sv ====
// tester top; tx and rx are independent streams, loop them outside for a self test
module pkt_test_top #(
	parameter int LANES = 2
) (
	input  logic                                  clk,
	input  logic                                  arst_n,
	// register port
	input  logic                                  reg_wr,
	input  logic                                  reg_rd,
	input  logic [3:0]                            reg_addr,
	input  logic [31:0]                           reg_wdata,
	output logic [31:0]                           reg_rdata,
	// stream ports
	output pkt_test_pkg::lane_beat_t [LANES-1:0]  tx_beat,
	input  logic                                  tx_ready,
	input  pkt_test_pkg::lane_beat_t [LANES-1:0]  rx_beat,
	input  logic                                  rx_valid
);
	pkt_test_pkg::gen_cfg_t cfg;
	logic                   clear;
	logic [31:0]            pkt_sent;
	logic [31:0]            pkt_rcvd;
	logic [15:0]            err_count;
	// counters gathered for the read mux
	wire pkt_test_pkg::stat_t stat = {pkt_sent, pkt_rcvd, err_count};

	pkt_test_csr csr_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.stat      (stat),
		.cfg       (cfg),
		.clear     (clear)
	);

	packet_gen #(.LANES(LANES)) gen_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg      (cfg),
		.clear    (clear),
		.tx_ready (tx_ready),
		.tx_beat  (tx_beat),
		.pkt_sent (pkt_sent)
	);

	packet_check #(.LANES(LANES)) check_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.rx_beat   (rx_beat),
		.rx_valid  (rx_valid),
		.clear     (clear),
		.pkt_rcvd  (pkt_rcvd),
		.err_count (err_count)
	);

endmodule

// ==== tests/pkt_test_props.sv ====
// watches the top ports; expects CTRL changes only while no packet is open on tx
module pkt_test_props #(
	parameter int LANES = 2
) (
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  logic                                  reg_wr,
	input  logic [3:0]                            reg_addr,
	input  logic [31:0]                           reg_wdata,
	input  pkt_test_pkg::lane_beat_t [LANES-1:0]  tx_beat,
	input  logic                                  tx_ready,
	input  pkt_test_pkg::lane_beat_t [LANES-1:0]  rx_beat,
	input  logic                                  rx_valid,
	output int                                    errors,
	output int                                    tx_starts,
	output int                                    rx_starts,
	output logic                                  tx_open
);
	timeunit 1ns;
	timeprecision 1ps;

	// mirror of the control register
	logic run_q;
	logic gap_q;
	logic cntr_q;
	// accepted cycles since run fell
	int idle_cnt;
	logic prev_sop;
	logic [LANES-1:0][15:0] exp_ser;
	logic [LANES-1:0][63:0] last_mid;
	logic [LANES-1:0] mid_ok;
	logic clr;

	assign clr = reg_wr && (reg_addr == pkt_test_pkg::REG_ERR);

	//////////////////////////////////////////////////////////////////////
	// tx stream, accepted beats only
	always @(posedge clk or negedge arst_n) begin : tx_watch
		pkt_test_pkg::lane_beat_t b;
		logic open;
		logic any_sop;
		int n_err;
		int n_sop;
		if (!arst_n) begin
			run_q     <= 1'b0;
			gap_q     <= 1'b0;
			cntr_q    <= 1'b0;
			idle_cnt  <= 0;
			prev_sop  <= 1'b0;
			exp_ser   <= '0;
			last_mid  <= '0;
			mid_ok    <= '0;
			errors    <= 0;
			tx_starts <= 0;
			tx_open   <= 1'b0;
		end else begin
			open = tx_open;
			any_sop = 1'b0;
			n_err = 0;
			n_sop = 0;
			if (reg_wr && reg_addr == pkt_test_pkg::REG_CTRL) begin
				run_q  <= reg_wdata[0];
				gap_q  <= reg_wdata[1];
				cntr_q <= reg_wdata[2];
			end
			if (tx_ready) begin
				// highest lane first in time
				for (int i = LANES - 1; i >= 0; i--) begin
					b = tx_beat[i];
					assert (!(b.sop && b.eop != 8'h00))
					else begin
						$display("lane %0d holds a start and an end in one beat", i);
						n_err++;
					end
					if (b.sop) begin
						assert (!open)
						else begin
							$display("lane %0d starts a packet inside an open one", i);
							n_err++;
						end
						assert (run_q || idle_cnt < 8)
						else begin
							$display("lane %0d starts %0d cycles after run was cleared", i, idle_cnt);
							n_err++;
						end
						assert (b.data[63:16] == pkt_test_pkg::DEST_ADDR[i % 5])
						else begin
							$display("ERROR tx_beat[%0d].data[63:16] 0x%012h expected 0x%012h",
								i, b.data[63:16], pkt_test_pkg::DEST_ADDR[i % 5]);
							n_err++;
						end
						assert (b.data[15:0] == exp_ser[i])
						else begin
							$display("ERROR tx_beat[%0d].data[15:0] 0x%04h expected 0x%04h",
								i, b.data[15:0], exp_ser[i]);
							n_err++;
						end
						// follow the stream after a miss
						exp_ser[i] <= b.data[15:0] + 16'd1;
						open = 1'b1;
						any_sop = 1'b1;
						n_sop++;
					end
					if (b.eop != 8'h00) begin
						assert ($onehot(b.eop))
						else begin
							$display("ERROR tx_beat[%0d].eop 0x%02h not one-hot", i, b.eop);
							n_err++;
						end
						assert (open)
						else begin
							$display("lane %0d ends a packet that was never started", i);
							n_err++;
						end
						assert (b.data == pkt_test_pkg::CABOOSE)
						else begin
							$display("ERROR tx_beat[%0d].data 0x%016h expected 0x%016h",
								i, b.data, pkt_test_pkg::CABOOSE);
							n_err++;
						end
						open = 1'b0;
					end
					// counter middle beats step by one within a lane
					if (open && !b.sop && b.eop == 8'h00 && cntr_q) begin
						assert (!mid_ok[i] || b.data == last_mid[i] + 64'd1)
						else begin
							$display("ERROR tx_beat[%0d].data 0x%016h expected 0x%016h",
								i, b.data, last_mid[i] + 64'd1);
							n_err++;
						end
						last_mid[i] <= b.data;
						mid_ok[i]   <= 1'b1;
					end
				end
				assert (!(gap_q && prev_sop && any_sop))
				else begin
					$display("two accepted cycles in a row hold a start with gap mode on");
					n_err++;
				end
				prev_sop <= any_sop;
				tx_open  <= open;
				idle_cnt <= run_q ? 0 : idle_cnt + 1;
			end
			if (!cntr_q || clr)
				mid_ok <= '0;
			if (clr)
				exp_ser <= '0;
			errors    <= errors + n_err;
			tx_starts <= clr ? 0 : tx_starts + n_sop;
		end
	end

	// rx starts, the reference for REG_RCVD
	always @(posedge clk or negedge arst_n) begin : rx_watch
		int n;
		if (!arst_n) begin
			rx_starts <= 0;
		end else begin
			n = 0;
			for (int i = 0; i < LANES; i++)
				if (rx_valid && rx_beat[i].sop)
					n++;
			rx_starts <= clr ? 0 : rx_starts + n;
		end
	end

endmodule

// ==== tests/pkt_test_tb.sv ====
// loopback testbench; LANES must match the DUT and CTRL is only rewritten once tx is drained
module pkt_test_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LANES = 2;
	// traffic phase lengths in cycles
	localparam int PH_BASIC = 400;
	localparam int PH_GAP   = 600;
	localparam int PH_CNTR  = 400;
	// the margin covers drains and register access
	localparam int WATCHDOG_NS = (PH_BASIC + PH_GAP + PH_CNTR) * 8 * 3 + 40000;

	logic        clk;
	logic        arst_n;
	logic        reg_wr;
	logic        reg_rd;
	logic [3:0]  reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic        tx_ready;
	logic        corrupt;
	logic        tx_open;
	pkt_test_pkg::lane_beat_t [LANES-1:0] tx_beat;
	pkt_test_pkg::lane_beat_t [LANES-1:0] rx_beat;
	pkt_test_pkg::lane_beat_t [LANES-1:0] flip;
	int tb_errors;
	int prop_errors;
	int tx_starts;
	int rx_starts;
	int flips;

	// rx takes a beat whenever tx does
	assign rx_beat = tx_beat ^ flip;

	pkt_test_top #(.LANES(LANES)) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.reg_wr    (reg_wr),
		.reg_rd    (reg_rd),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.tx_beat   (tx_beat),
		.tx_ready  (tx_ready),
		.rx_beat   (rx_beat),
		.rx_valid  (tx_ready)
	);

	pkt_test_props #(.LANES(LANES)) props_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.tx_beat   (tx_beat),
		.tx_ready  (tx_ready),
		.rx_beat   (rx_beat),
		.rx_valid  (tx_ready),
		.errors    (prop_errors),
		.tx_starts (tx_starts),
		.rx_starts (rx_starts),
		.tx_open   (tx_open)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the last phase finished");
		$display("Verification failed");
		$finish;
	end

	// address flips taken by the checker and cleared with the DUT counters
	always @(posedge clk) begin : flip_count
		int n;
		n = 0;
		for (int i = 0; i < LANES; i++)
			if (flip[i].data != 64'd0)
				n++;
		if (reg_wr && reg_addr == pkt_test_pkg::REG_ERR)
			flips <= 0;
		else if (tx_ready)
			flips <= flips + n;
	end

	//////////////////////////////////////////////////////////////////////
	// register access and traffic
	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		@(negedge clk);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	task automatic read_check(input logic [3:0] addr, input logic [31:0] expected,
		input string name);
		@(negedge clk);
		reg_rd   = 1'b1;
		reg_addr = addr;
		// data registered on the edge in between
		@(negedge clk);
		reg_rd = 1'b0;
		assert (reg_rdata == expected)
		else begin
			$display("ERROR reg_rdata %s 0x%08h expected 0x%08h", name, reg_rdata, expected);
			tb_errors++;
		end
	endtask

	task automatic traffic(input int cycles, input logic stall);
		int starts_before;
		starts_before = tx_starts;
		repeat (cycles) begin
			@(negedge clk);
			tx_ready = stall ? (($urandom % 4) != 0) : 1'b1;
			flip = '0;
			// one address bit per start beat
			if (corrupt)
				for (int i = 0; i < LANES; i++)
					if (tx_beat[i].sop)
						flip[i].data = 64'd1 << (16 + $urandom % 48);
		end
		@(negedge clk);
		tx_ready = 1'b1;
		flip = '0;
		// every phase has to reach the stream checks
		assert (tx_starts > starts_before)
		else begin
			$display("no packet was sent during a traffic phase");
			tb_errors++;
		end
	endtask

	task automatic drain();
		int waited;
		reg_write(pkt_test_pkg::REG_CTRL, 32'h0);
		repeat (8) @(negedge clk);
		waited = 0;
		while (tx_open && waited < 1000) begin
			@(negedge clk);
			waited++;
		end
		assert (!tx_open)
		else begin
			$display("a packet was still open 1000 cycles after run was cleared");
			tb_errors++;
		end
	endtask

	task automatic check_counters();
		read_check(pkt_test_pkg::REG_SENT, 32'(tx_starts), "REG_SENT");
		read_check(pkt_test_pkg::REG_RCVD, 32'(rx_starts), "REG_RCVD");
		read_check(pkt_test_pkg::REG_ERR, 32'(flips), "REG_ERR");
	endtask

	initial begin
		void'($urandom(32'hbe068826));
		arst_n    = 1'b0;
		reg_wr    = 1'b0;
		reg_rd    = 1'b0;
		reg_addr  = '0;
		reg_wdata = '0;
		tx_ready  = 1'b1;
		flip      = '0;
		corrupt   = 1'b0;
		tb_errors = 0;
		repeat (16) @(negedge clk);
		arst_n = 1'b1;
		read_check(pkt_test_pkg::REG_CTRL, 32'h0, "REG_CTRL");
		read_check(pkt_test_pkg::REG_SEED, 32'hffff_ffff, "REG_SEED");
		reg_write(pkt_test_pkg::REG_SEED, 32'h2468_ace1);
		read_check(pkt_test_pkg::REG_SEED, 32'h2468_ace1, "REG_SEED");
		// full rate with corrupted addresses on rx
		corrupt = 1'b1;
		reg_write(pkt_test_pkg::REG_CTRL, 32'h1);
		traffic(PH_BASIC, 1'b0);
		corrupt = 1'b0;
		drain();
		check_counters();
		// gap mode under random stalls
		reg_write(pkt_test_pkg::REG_CTRL, 32'h3);
		traffic(PH_GAP, 1'b1);
		drain();
		// counter payload under random stalls
		reg_write(pkt_test_pkg::REG_CTRL, 32'h5);
		traffic(PH_CNTR, 1'b1);
		drain();
		check_counters();
		reg_write(pkt_test_pkg::REG_ERR, 32'h0);
		read_check(pkt_test_pkg::REG_SENT, 32'h0, "REG_SENT");
		read_check(pkt_test_pkg::REG_RCVD, 32'h0, "REG_RCVD");
		read_check(pkt_test_pkg::REG_ERR, 32'h0, "REG_ERR");
		@(negedge clk);
		$display("errors: %0d register, %0d stream", tb_errors, prop_errors);
		if (tb_errors == 0 && prop_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== src.f ====
hw/pkt_test_pkg.sv
hw/prbs_source.sv
hw/payload_filler.sv
hw/packet_gen.sv
hw/packet_check.sv
hw/pkt_test_csr.sv
hw/pkt_test_top.sv
tests/pkt_test_props.sv
tests/pkt_test_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and pass only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f src.f --top-module pkt_test_tb -o pkt_test_sim &&
	sim_out=$(./obj_dir/pkt_test_sim) &&
	echo "$sim_out" &&
	grep -q "^Verification passed$" <<< "$sim_out" ||
	{ echo "run.sh: simulation did not pass"; exit 1; }
